// ==== rtl/rf_pg_pkg.sv ====
// Shared constants for the power-gated register file, with one clock and full-entry writes only
package rf_pg_pkg;

    // ----------------------------------------------------------------------
    // Array geometry
    // ----------------------------------------------------------------------

    // Logical view seen by the bus
    localparam int RF_DEPTH  = 512;
    localparam int RF_ADDR_W = 9;
    localparam int RF_DATA_W = 15;

    // The macro is one bit wider than the logical word
    localparam int RF_PHYS_W = 16;

    // Cycles for the power-enable chain to echo a change on its input
    localparam int PWR_CHAIN_DELAY = 4;

    // ----------------------------------------------------------------------
    // Bus and register map
    // ----------------------------------------------------------------------

    localparam int AXI_ADDR_W = 12;
    localparam int AXI_DATA_W = 32;

    // Everything below CTRL_ADDR is the word window onto the array
    // Bit 0 of the control register requests power-down
    localparam logic [AXI_ADDR_W-1:0] CTRL_ADDR = 12'h800;

    // Status bit 0 is powered and usable, bit 1 is isolated
    localparam logic [AXI_ADDR_W-1:0] STAT_ADDR = 12'h804;

    // Power-gating sequencer states, in the order they are visited
    typedef enum logic [2:0] {
        PG_ON,
        PG_ISOLATE,
        PG_PWR_DOWN,
        PG_OFF,
        PG_PWR_UP,
        PG_DEISOLATE
    } pg_state_e;

    // Response codes as encoded on BRESP and RRESP
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

// ==== rtl/mem_reset_sync.sv ====
// Reset synchroniser for the macro, async assert and two-flop release, scan may override the output
`timescale 1ns/1ps

module mem_reset_sync (
     input  logic clk
    ,input  logic rst_n
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic rst_n_sync
);

// ----------------------------------------------------------------------
// Two-flop release
// ----------------------------------------------------------------------

// Shift register that fills with ones after reset goes away
logic [1:0] sync_q;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        sync_q <= 2'b00;
    end else begin
        sync_q <= {sync_q[0], 1'b1};
    end
end

// In scan mode the tester owns the macro reset directly
assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[1];

endmodule

// ==== rtl/rf_array_2p_512x16.sv ====
// Behavioural two-port macro model, contents clear at power-down, isolated output reads zero
`timescale 1ns/1ps

module rf_array_2p_512x16 import rf_pg_pkg::*; (
     input  logic                 wclk
    ,input  logic                 we
    ,input  logic [RF_ADDR_W-1:0] waddr
    ,input  logic [RF_PHYS_W-1:0] wdata

    ,input  logic                 rclk
    ,input  logic                 re
    ,input  logic [RF_ADDR_W-1:0] raddr
    ,output logic [RF_PHYS_W-1:0] rdata

    ,input  logic                 ip_reset_b
    ,input  logic                 isol_en
    ,input  logic                 pwr_en_b_in
    ,output logic                 pwr_en_b_out
    ,input  logic                 fscan_clkungate
);

logic [RF_PHYS_W-1:0]       mem [RF_DEPTH];
logic [RF_PHYS_W-1:0]       rdata_q;
logic [PWR_CHAIN_DELAY-1:0] pwr_chain_q;
logic                       array_on;
logic                       wr_clk_en;
logic                       rd_clk_en;

// The power enable is active low
assign array_on = !pwr_en_b_in;

// Internal clock gates open on a request, or always while scan ungates them
assign wr_clk_en = we | fscan_clkungate;
assign rd_clk_en = re | fscan_clkungate;

// ----------------------------------------------------------------------
// Storage
// ----------------------------------------------------------------------

// Losing power wipes every bitcell, so nothing survives a power cycle
always_ff @(posedge wclk) begin
    if (!array_on) begin
        for (int i = 0; i < RF_DEPTH; i++) begin
            mem[i] <= '0;
        end
    end else if (wr_clk_en && we) begin
        mem[waddr] <= wdata;
    end
end

// Registered read port, one cycle from re to data
always_ff @(posedge rclk or negedge ip_reset_b) begin
    if (!ip_reset_b) begin
        rdata_q <= '0;
    end else if (rd_clk_en && re) begin
        rdata_q <= array_on ? mem[raddr] : '0;
    end
end

// Clamp cells hold the output low during isolation
assign rdata = isol_en ? '0 : rdata_q;

// ----------------------------------------------------------------------
// Power-enable chain
// ----------------------------------------------------------------------

// Models the daisy chain of switch segments turning on one after another
always_ff @(posedge rclk or negedge ip_reset_b) begin
    if (!ip_reset_b) begin
        pwr_chain_q <= '0;
    end else begin
        pwr_chain_q <= {pwr_chain_q[PWR_CHAIN_DELAY-2:0], pwr_en_b_in};
    end
end

assign pwr_en_b_out = pwr_chain_q[PWR_CHAIN_DELAY-1];

endmodule

// ==== rtl/rf_pg_512x15.sv ====
// Wrapper for the 512x15 register file on a 16-bit macro, top physical bit always written as zero
`timescale 1ns/1ps

module rf_pg_512x15 import rf_pg_pkg::*; (
     input  logic                 wclk
    ,input  logic                 rst_n
    ,input  logic                 we
    ,input  logic [RF_ADDR_W-1:0] waddr
    ,input  logic [RF_DATA_W-1:0] wdata

    ,input  logic                 rclk
    ,input  logic                 re
    ,input  logic [RF_ADDR_W-1:0] raddr
    ,output logic [RF_DATA_W-1:0] rdata

    // Power interface
    ,input  logic                 pgcb_isol_en
    ,input  logic                 pwr_enable_b_in
    ,output logic                 pwr_enable_b_out

    ,input  logic                 ip_reset_b
    ,input  logic                 fscan_byprst_b
    ,input  logic                 fscan_clkungate
    ,input  logic                 fscan_rstbypen
);

logic [RF_PHYS_W-1:0] rdata_phys;
logic                 mem_rst_n;
logic                 ip_reset_b_sync;

// Macro stays in reset while either the system or the IP reset is low
assign mem_rst_n = rst_n & ip_reset_b;

mem_reset_sync i_ip_reset_b_sync (
     .clk             (rclk)
    ,.rst_n           (mem_rst_n)
    ,.fscan_rstbypen  (fscan_rstbypen)
    ,.fscan_byprst_b  (fscan_byprst_b)
    ,.rst_n_sync      (ip_reset_b_sync)
);

// ----------------------------------------------------------------------
// Macro
// ----------------------------------------------------------------------

rf_array_2p_512x16 i_rf (
     .wclk            (wclk)
    ,.we              (we)
    ,.waddr           (waddr)
    ,.wdata           ({1'b0, wdata})
    ,.rclk            (rclk)
    ,.re              (re)
    ,.raddr           (raddr)
    ,.rdata           (rdata_phys)
    ,.ip_reset_b      (ip_reset_b_sync)
    ,.isol_en         (pgcb_isol_en)
    ,.pwr_en_b_in     (pwr_enable_b_in)
    ,.pwr_en_b_out    (pwr_enable_b_out)
    ,.fscan_clkungate (fscan_clkungate)
);

// The padding bit is dropped on the way out
assign rdata = rdata_phys[RF_DATA_W-1:0];

endmodule

// ==== rtl/rf_power_ctrl.sv ====
// Power-gating sequencer, waits on the echoed enable so any chain delay works
`timescale 1ns/1ps

module rf_power_ctrl import rf_pg_pkg::*; (
     input  logic clk
    ,input  logic rst_n
    ,input  logic pg_req
    ,input  logic pwr_enable_b_out
    ,output logic pgcb_isol_en
    ,output logic pwr_enable_b_in
    ,output logic pg_ready
    ,output logic pg_isolated
);

pg_state_e state_q;
pg_state_e state_d;

// ----------------------------------------------------------------------
// Next state
// ----------------------------------------------------------------------

always_comb begin
    state_d = state_q;
    case (state_q)
        PG_ON: begin
            if (pg_req) begin
                state_d = PG_ISOLATE;
            end
        end
        // Clamps settle for one cycle before the rails drop
        PG_ISOLATE: begin
            state_d = PG_PWR_DOWN;
        end
        // Stay here until the whole chain reports off
        PG_PWR_DOWN: begin
            if (pwr_enable_b_out) begin
                state_d = PG_OFF;
            end
        end
        PG_OFF: begin
            if (!pg_req) begin
                state_d = PG_PWR_UP;
            end
        end
        // Stay here until the whole chain reports on
        PG_PWR_UP: begin
            if (!pwr_enable_b_out) begin
                state_d = PG_DEISOLATE;
            end
        end
        PG_DEISOLATE: begin
            state_d = PG_ON;
        end
        default: begin
            state_d = PG_ON;
        end
    endcase
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state_q <= PG_ON;
    end else begin
        state_q <= state_d;
    end
end

// ----------------------------------------------------------------------
// Outputs
// ----------------------------------------------------------------------

// Isolation wraps the whole time the rails are not fully on
assign pgcb_isol_en    = state_q inside {PG_ISOLATE, PG_PWR_DOWN, PG_OFF, PG_PWR_UP};
assign pwr_enable_b_in = state_q inside {PG_PWR_DOWN, PG_OFF};

// Only a fully settled array is offered to the bus
assign pg_ready    = state_q == PG_ON;
assign pg_isolated = pgcb_isol_en;

endmodule

// ==== rtl/rf_axil_slave.sv ====
// AXI4-Lite slave, one transfer per channel in flight, no write strobes
`timescale 1ns/1ps

module rf_axil_slave import rf_pg_pkg::*; (
     input  logic                  clk
    ,input  logic                  rst_n

    // Write address, data and response channels
    ,input  logic                  awvalid
    ,output logic                  awready
    ,input  logic [AXI_ADDR_W-1:0] awaddr
    ,input  logic                  wvalid
    ,output logic                  wready
    ,input  logic [AXI_DATA_W-1:0] wdata
    ,output logic                  bvalid
    ,input  logic                  bready
    ,output axi_resp_e             bresp

    // Read address and data channels
    ,input  logic                  arvalid
    ,output logic                  arready
    ,input  logic [AXI_ADDR_W-1:0] araddr
    ,output logic                  rvalid
    ,input  logic                  rready
    ,output logic [AXI_DATA_W-1:0] rdata
    ,output axi_resp_e             rresp

    // Register file ports
    ,output logic                  rf_we
    ,output logic [RF_ADDR_W-1:0]  rf_waddr
    ,output logic [RF_DATA_W-1:0]  rf_wdata
    ,output logic                  rf_re
    ,output logic [RF_ADDR_W-1:0]  rf_raddr
    ,input  logic [RF_DATA_W-1:0]  rf_rdata

    // Power sequencer
    ,output logic                  pg_req
    ,input  logic                  pg_ready
    ,input  logic                  pg_isolated
);

logic                  wr_ready_q;
logic                  wr_fire;
logic                  wr_in_window;
logic                  wr_is_reg;
axi_resp_e             wr_resp;
logic                  ctrl_q;

logic                  rd_fire;
logic                  rd_in_window;
logic                  rd_is_ctrl;
logic                  rd_is_stat;
axi_resp_e             rd_resp;
logic [AXI_DATA_W-1:0] rd_reg_data;
logic                  rd_s1_q;
logic                  rd_s2_q;
logic                  rd_from_rf_q;
logic [RF_ADDR_W-1:0]  raddr_q;
axi_resp_e             rd_resp_q;
logic [AXI_DATA_W-1:0] rd_reg_data_q;

// ----------------------------------------------------------------------
// Write path
// ----------------------------------------------------------------------

assign awready = wr_ready_q;
assign wready  = wr_ready_q;
assign wr_fire = awvalid && wvalid && wr_ready_q;

assign wr_in_window = awaddr < CTRL_ADDR;
assign wr_is_reg    = (awaddr == CTRL_ADDR) || (awaddr == STAT_ADDR);

// Window writes need a powered array, status writes are accepted and ignored
assign wr_resp = ((wr_in_window && pg_ready) || wr_is_reg) ? RESP_OKAY : RESP_SLVERR;

// The entry is written on the acceptance edge itself
assign rf_we    = wr_fire && wr_in_window && pg_ready;
assign rf_waddr = awaddr[RF_ADDR_W+1:2];
assign rf_wdata = wdata[RF_DATA_W-1:0];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        wr_ready_q <= 1'b0;
        bvalid     <= 1'b0;
        ctrl_q     <= 1'b0;
    end else begin
        // Single-cycle ready pulse once address and data are both present
        wr_ready_q <= !wr_ready_q && awvalid && wvalid && !bvalid;
        if (wr_fire) begin
            bvalid <= 1'b1;
            if (awaddr == CTRL_ADDR) begin
                ctrl_q <= wdata[0];
            end
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (wr_fire) begin
        bresp <= wr_resp;
    end
end

assign pg_req = ctrl_q;

// ----------------------------------------------------------------------
// Read path
// ----------------------------------------------------------------------

assign rd_fire      = arvalid && arready;
assign rd_in_window = araddr < CTRL_ADDR;
assign rd_is_ctrl   = araddr == CTRL_ADDR;
assign rd_is_stat   = araddr == STAT_ADDR;

assign rd_resp = ((rd_in_window && pg_ready) || rd_is_ctrl || rd_is_stat) ?
                 RESP_OKAY : RESP_SLVERR;

// Register values are sampled at acceptance, unmapped and unpowered reads give zero
always_comb begin
    rd_reg_data = '0;
    if (rd_is_ctrl) begin
        rd_reg_data[0] = ctrl_q;
    end
    if (rd_is_stat) begin
        rd_reg_data[1:0] = {pg_isolated, pg_ready};
    end
end

// Macro read is issued the cycle after acceptance
assign rf_re    = rd_s1_q && rd_from_rf_q;
assign rf_raddr = raddr_q;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        arready <= 1'b0;
        rd_s1_q <= 1'b0;
        rd_s2_q <= 1'b0;
        rvalid  <= 1'b0;
    end else begin
        rd_s1_q <= rd_fire;
        rd_s2_q <= rd_s1_q;
        // Reopen the address channel only once the previous response has gone
        if (rd_fire) begin
            arready <= 1'b0;
        end else if (!rd_s1_q && !rd_s2_q && !rvalid) begin
            arready <= 1'b1;
        end
        if (rd_s2_q) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (rd_fire) begin
        raddr_q       <= araddr[RF_ADDR_W+1:2];
        rd_from_rf_q  <= rd_in_window && pg_ready;
        rd_resp_q     <= rd_resp;
        rd_reg_data_q <= rd_reg_data;
    end
    // Macro output register is valid two cycles after acceptance
    if (rd_s2_q) begin
        rdata <= rd_from_rf_q ? {{(AXI_DATA_W-RF_DATA_W){1'b0}}, rf_rdata} : rd_reg_data_q;
        rresp <= rd_resp_q;
    end
end

endmodule

// ==== rtl/rf_pg_subsys.sv ====
// Top of the power-gated register file subsystem, single clock, IP reset tied to system reset
`timescale 1ns/1ps

module rf_pg_subsys import rf_pg_pkg::*; (
     input  logic                  clk
    ,input  logic                  rst_n

    ,input  logic                  awvalid
    ,output logic                  awready
    ,input  logic [AXI_ADDR_W-1:0] awaddr
    ,input  logic                  wvalid
    ,output logic                  wready
    ,input  logic [AXI_DATA_W-1:0] wdata
    ,output logic                  bvalid
    ,input  logic                  bready
    ,output axi_resp_e             bresp

    ,input  logic                  arvalid
    ,output logic                  arready
    ,input  logic [AXI_ADDR_W-1:0] araddr
    ,output logic                  rvalid
    ,input  logic                  rready
    ,output logic [AXI_DATA_W-1:0] rdata
    ,output axi_resp_e             rresp

    ,input  logic                  fscan_byprst_b
    ,input  logic                  fscan_rstbypen
    ,input  logic                  fscan_clkungate
);

// ----------------------------------------------------------------------
// Internal nets
// ----------------------------------------------------------------------

logic                 rf_we;
logic [RF_ADDR_W-1:0] rf_waddr;
logic [RF_DATA_W-1:0] rf_wdata;
logic                 rf_re;
logic [RF_ADDR_W-1:0] rf_raddr;
logic [RF_DATA_W-1:0] rf_rdata;
logic                 pg_req;
logic                 pg_ready;
logic                 pg_isolated;
logic                 pgcb_isol_en;
logic                 pwr_enable_b_in;
logic                 pwr_enable_b_out;

rf_axil_slave i_rf_axil_slave (
     .clk         (clk)
    ,.rst_n       (rst_n)
    ,.awvalid     (awvalid)
    ,.awready     (awready)
    ,.awaddr      (awaddr)
    ,.wvalid      (wvalid)
    ,.wready      (wready)
    ,.wdata       (wdata)
    ,.bvalid      (bvalid)
    ,.bready      (bready)
    ,.bresp       (bresp)
    ,.arvalid     (arvalid)
    ,.arready     (arready)
    ,.araddr      (araddr)
    ,.rvalid      (rvalid)
    ,.rready      (rready)
    ,.rdata       (rdata)
    ,.rresp       (rresp)
    ,.rf_we       (rf_we)
    ,.rf_waddr    (rf_waddr)
    ,.rf_wdata    (rf_wdata)
    ,.rf_re       (rf_re)
    ,.rf_raddr    (rf_raddr)
    ,.rf_rdata    (rf_rdata)
    ,.pg_req      (pg_req)
    ,.pg_ready    (pg_ready)
    ,.pg_isolated (pg_isolated)
);

rf_power_ctrl i_rf_power_ctrl (
     .clk              (clk)
    ,.rst_n            (rst_n)
    ,.pg_req           (pg_req)
    ,.pwr_enable_b_out (pwr_enable_b_out)
    ,.pgcb_isol_en     (pgcb_isol_en)
    ,.pwr_enable_b_in  (pwr_enable_b_in)
    ,.pg_ready         (pg_ready)
    ,.pg_isolated      (pg_isolated)
);

// Both macro ports run on the one system clock
rf_pg_512x15 i_rf_pg_512x15 (
     .wclk             (clk)
    ,.rst_n            (rst_n)
    ,.we               (rf_we)
    ,.waddr            (rf_waddr)
    ,.wdata            (rf_wdata)
    ,.rclk             (clk)
    ,.re               (rf_re)
    ,.raddr            (rf_raddr)
    ,.rdata            (rf_rdata)
    ,.pgcb_isol_en     (pgcb_isol_en)
    ,.pwr_enable_b_in  (pwr_enable_b_in)
    ,.pwr_enable_b_out (pwr_enable_b_out)
    ,.ip_reset_b       (rst_n)
    ,.fscan_byprst_b   (fscan_byprst_b)
    ,.fscan_clkungate  (fscan_clkungate)
    ,.fscan_rstbypen   (fscan_rstbypen)
);

endmodule

// ==== testbench/rf_pg_subsys_properties.sv ====
// Bound protocol checks on the subsystem top, error_count is nonzero once any assertion has failed
`timescale 1ns/1ps

module rf_pg_subsys_properties import rf_pg_pkg::*; (
     input  logic                  clk
    ,input  logic                  rst_n
    ,input  logic                  bvalid
    ,input  logic                  bready
    ,input  axi_resp_e             bresp
    ,input  logic                  arvalid
    ,input  logic                  arready
    ,input  logic [AXI_ADDR_W-1:0] araddr
    ,input  logic                  rvalid
    ,input  logic                  rready
    ,input  logic [AXI_DATA_W-1:0] rdata
    ,input  axi_resp_e             rresp
    ,input  logic                  pgcb_isol_en
    ,input  logic                  pwr_enable_b_in
    ,input  logic                  pg_ready
);

int error_count = 0;

// ----------------------------------------------------------------------
// Response channels
// ----------------------------------------------------------------------

// A pending write response keeps its code until the master takes it
assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        error_count = error_count + 1;
        $error("Write response dropped or changed before bready");
    end

// Same for the read data channel, data and code both held
assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        error_count = error_count + 1;
        $error("Read response dropped or changed before rready");
    end

// Nothing is offered to the master while reset is applied
assert property (@(posedge clk) !rst_n |-> !bvalid && !rvalid)
    else begin
        error_count = error_count + 1;
        $error("Response valid seen during reset");
    end

// ----------------------------------------------------------------------
// Power protocol
// ----------------------------------------------------------------------

// Rails may only be off behind the clamps
assert property (@(posedge clk) disable iff (!rst_n)
    pwr_enable_b_in |-> pgcb_isol_en)
    else begin
        error_count = error_count + 1;
        $error("Power enable deasserted without isolation");
    end

// Window read accepted while unpowered answers SLVERR three edges later
assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && arready && !pg_ready && (araddr < CTRL_ADDR)
    |-> ##3 rvalid && (rresp == RESP_SLVERR))
    else begin
        error_count = error_count + 1;
        $error("Unpowered array read did not return SLVERR");
    end

endmodule

bind rf_pg_subsys rf_pg_subsys_properties i_rf_pg_subsys_properties (
     .clk             (clk)
    ,.rst_n           (rst_n)
    ,.bvalid          (bvalid)
    ,.bready          (bready)
    ,.bresp           (bresp)
    ,.arvalid         (arvalid)
    ,.arready         (arready)
    ,.araddr          (araddr)
    ,.rvalid          (rvalid)
    ,.rready          (rready)
    ,.rdata           (rdata)
    ,.rresp           (rresp)
    ,.pgcb_isol_en    (pgcb_isol_en)
    ,.pwr_enable_b_in (pwr_enable_b_in)
    ,.pg_ready        (pg_ready)
);

// ==== testbench/rf_pg_subsys_tb.sv ====
// Drives one AXI transfer at a time and samples DUT outputs on the falling clock edge
`timescale 1ns/1ps

module rf_pg_subsys_tb;
import rf_pg_pkg::*;

// Roughly three times the length of the whole sequence
localparam int TIMEOUT_CYCLES = 3000;

logic                  clk;
logic                  rst_n;
logic                  awvalid;
logic                  awready;
logic [AXI_ADDR_W-1:0] awaddr;
logic                  wvalid;
logic                  wready;
logic [AXI_DATA_W-1:0] wdata;
logic                  bvalid;
logic                  bready;
axi_resp_e             bresp;
logic                  arvalid;
logic                  arready;
logic [AXI_ADDR_W-1:0] araddr;
logic                  rvalid;
logic                  rready;
logic [AXI_DATA_W-1:0] rdata;
axi_resp_e             rresp;
logic                  fscan_byprst_b;
logic                  fscan_rstbypen;
logic                  fscan_clkungate;

logic [15:0]          lfsr_state = 16'd12257;
logic [RF_DATA_W-1:0] shadow [RF_DEPTH];
int                   written_idx [$];
int                   cycle_count = 0;

rf_pg_subsys i_rf_pg_subsys (.*);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

// ----------------------------------------------------------------------
// Checking and stimulus helpers
// ----------------------------------------------------------------------

task automatic check_equal(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected) else begin
        $display("Fail %s expected 0x%0h actual 0x%0h", name, expected, actual);
        $display("Regression failed");
        $fatal(1, "Value mismatch on %s", name);
    end
endtask

task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "Check failed");
    end
endtask

// Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// One LFSR step for every bit handed out
task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
        value = {value[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
endtask

// Holding ready low for hold cycles leaves the response pending
task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                         input int hold, output logic [1:0] resp);
    logic [1:0] held_resp;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    check_true(wready, "wready did not rise together with awready");
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    held_resp = bresp;
    repeat (hold) begin
        @(negedge clk);
        check_true(bvalid, "Write response went away while bready was low");
        check_equal("bresp", held_resp, bresp);
    end
    @(posedge clk);
    #2 bready = 1'b1;
    @(posedge clk);
    #2 bready = 1'b0;
    resp = held_resp;
endtask

task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, input int hold,
                        output logic [31:0] data, output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #2 arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    repeat (hold) begin
        @(negedge clk);
        check_true(rvalid, "Read response went away while rready was low");
        check_equal("rdata", data, rdata);
        check_equal("rresp", resp, rresp);
    end
    @(posedge clk);
    #2 rready = 1'b1;
    @(posedge clk);
    #2 rready = 1'b0;
endtask

// Window byte address of an entry
function automatic logic [AXI_ADDR_W-1:0] entry_addr(input int idx);
    entry_addr = {1'b0, idx[RF_ADDR_W-1:0], 2'b00};
endfunction

// Reads an entry and compares it with the zero-extended expected word
task automatic read_expect(input int idx, input logic [RF_DATA_W-1:0] expected);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(entry_addr(idx), 0, data, resp);
    check_equal("rresp", RESP_OKAY, resp);
    check_equal("rdata", {17'd0, expected}, data);
endtask

// Polls the status register until it shows the wanted value
task automatic wait_status(input logic [31:0] wanted);
    logic [31:0] data;
    logic [1:0]  resp;
    data = '1;
    while (data !== wanted) begin
        axi_read(STAT_ADDR, 0, data, resp);
        check_equal("rresp", RESP_OKAY, resp);
    end
endtask

// Run limit and bound assertion monitor
always @(negedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("Regression failed");
        $fatal(1, "Timeout, the tests did not finish in time");
    end else if (i_rf_pg_subsys.i_rf_pg_subsys_properties.error_count != 0) begin
        $display("Regression failed");
        $fatal(1, "A bound protocol assertion failed");
    end
end

// ----------------------------------------------------------------------
// Test sequence
// ----------------------------------------------------------------------

initial begin
    logic [31:0] idx_bits;
    logic [31:0] data_bits;
    logic [31:0] data;
    logic [1:0]  resp;
    int          idx;
    rst_n           = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    fscan_byprst_b  = 1'b1;
    fscan_rstbypen  = 1'b0;
    fscan_clkungate = 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_true(!awready && !wready && !arready, "A ready output is high during reset");
    check_true(!bvalid && !rvalid, "A valid output is high during reset");
    @(posedge clk);
    #2 rst_n = 1'b1;
    // Give the macro reset synchroniser time to release
    repeat (3) @(posedge clk);
    #2;

    // Write random entries and data and read every one back
    for (int n = 0; n < 64; n++) begin
        take_bits(RF_ADDR_W, idx_bits);
        take_bits(32, data_bits);
        idx = idx_bits[RF_ADDR_W-1:0];
        axi_write(entry_addr(idx), data_bits, 0, resp);
        check_equal("bresp", RESP_OKAY, resp);
        shadow[idx] = data_bits[RF_DATA_W-1:0];
        written_idx.push_back(idx);
    end
    foreach (written_idx[k]) begin
        read_expect(written_idx[k], shadow[written_idx[k]]);
    end

    // Both ends of the array are independent
    take_bits(32, data_bits);
    axi_write(entry_addr(RF_DEPTH - 1), data_bits, 0, resp);
    check_equal("bresp", RESP_OKAY, resp);
    shadow[RF_DEPTH - 1] = data_bits[RF_DATA_W-1:0];
    take_bits(32, data_bits);
    axi_write(entry_addr(0), data_bits, 0, resp);
    check_equal("bresp", RESP_OKAY, resp);
    shadow[0] = data_bits[RF_DATA_W-1:0];
    written_idx.push_back(RF_DEPTH - 1);
    written_idx.push_back(0);
    read_expect(RF_DEPTH - 1, shadow[RF_DEPTH - 1]);
    read_expect(0, shadow[0]);

    // Once powered down the array refuses access
    axi_write(CTRL_ADDR, 32'h1, 0, resp);
    check_equal("bresp", RESP_OKAY, resp);
    axi_read(CTRL_ADDR, 0, data, resp);
    check_equal("rdata", 32'h1, data);
    wait_status(32'h2);
    axi_read(entry_addr(written_idx[0]), 0, data, resp);
    check_equal("rresp", RESP_SLVERR, resp);
    check_equal("rdata", 32'h0, data);
    axi_write(entry_addr(written_idx[1]), 32'h5A5A, 0, resp);
    check_equal("bresp", RESP_SLVERR, resp);

    // After power-up every bitcell comes back cleared
    axi_write(CTRL_ADDR, 32'h0, 0, resp);
    check_equal("bresp", RESP_OKAY, resp);
    wait_status(32'h1);
    foreach (written_idx[k]) begin
        read_expect(written_idx[k], '0);
        shadow[written_idx[k]] = '0;
    end

    // Unmapped address and control readback
    axi_write(12'h900, 32'h1234, 0, resp);
    check_equal("bresp", RESP_SLVERR, resp);
    axi_read(12'h900, 0, data, resp);
    check_equal("rresp", RESP_SLVERR, resp);
    check_equal("rdata", 32'h0, data);
    axi_read(CTRL_ADDR, 0, data, resp);
    check_equal("rresp", RESP_OKAY, resp);
    check_equal("rdata", 32'h0, data);

    // Back-pressure on both response channels
    take_bits(32, data_bits);
    axi_write(entry_addr(7), data_bits, 5, resp);
    check_equal("bresp", RESP_OKAY, resp);
    shadow[7] = data_bits[RF_DATA_W-1:0];
    axi_read(entry_addr(7), 5, data, resp);
    check_equal("rresp", RESP_OKAY, resp);
    check_equal("rdata", {17'd0, shadow[7]}, data);

    repeat (2) @(posedge clk);
    if (i_rf_pg_subsys.i_rf_pg_subsys_properties.error_count != 0) begin
        $display("Regression failed");
        $fatal(1, "A bound protocol assertion failed");
    end else begin
        $display("Regression passed");
        $finish;
    end
end

endmodule

// ==== rf_pg_subsys.f ====
rtl/rf_pg_pkg.sv
rtl/mem_reset_sync.sv
rtl/rf_array_2p_512x16.sv
rtl/rf_pg_512x15.sv
rtl/rf_power_ctrl.sv
rtl/rf_axil_slave.sv
rtl/rf_pg_subsys.sv
testbench/rf_pg_subsys_properties.sv
testbench/rf_pg_subsys_tb.sv
